// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= eth_dma_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/eth_burst_split.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_dma_settings.svh"

module eth_burst_split (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_dma_pkg::dma_job_t  job,
    input  logic                   start,
    input  logic [31:0]            pkt_data,
    input  logic                   pkt_valid,
    output logic                   pkt_ready,
    output eth_dma_pkg::mem_beat_t beat,
    output logic                   beat_valid,
    input  logic                   beat_ready
);

    localparam int SUM_W = `ETH_DMA_LEN_W + 1;
    localparam int CNT_W = SUM_W - 2;

    logic [1:0]       offset;
    logic [CNT_W-1:0] in_words;
    logic [CNT_W-1:0] out_beats;
    logic [CNT_W-1:0] words_left;
    logic [CNT_W-1:0] beats_left;
    logic             first_q;
    logic             last_beat;
    logic [23:0]      stored;
    logic             slot_free;
    logic             accept;
    logic             flush;
    logic             emit;
    logic [31:0]      src_word;
    logic [31:0]      shifted;
    logic [1:0]       end_lane;
    logic [3:0]       head_sel;
    logic [3:0]       tail_sel;
    logic [3:0]       beat_sel;

    assign offset = job.addr[1:0];

    // ceil(len/4) words in, ceil((offset+len)/4) beats out.
    assign in_words  = CNT_W'((SUM_W'(job.len) + SUM_W'(3)) >> 2);
    assign out_beats = CNT_W'((SUM_W'(job.len) + SUM_W'(offset) + SUM_W'(3)) >> 2);

    // ==========================================================
    // handshake
    // ==========================================================

    assign slot_free = beat_ready | ~beat_valid;
    assign pkt_ready = (words_left != '0) & slot_free;
    assign accept    = pkt_valid & pkt_ready;
    // leftover bytes spill into one more beat.
    assign flush     = (words_left == '0) & (beats_left != '0) & slot_free;
    assign emit      = accept | flush;

    // ==========================================================
    // realignment and byte selects
    // ==========================================================

    // flush shifts an empty word in behind the stored bytes.
    assign src_word = flush ? 32'h0 : pkt_data;
    assign shifted  = 32'({src_word, stored} >> {~offset, 3'b000});

    assign last_beat = (beats_left == CNT_W'(1));
    assign end_lane  = offset + job.len[1:0];
    assign head_sel  = 4'b1111 << offset;
    assign tail_sel  = (end_lane == 2'd0) ? 4'b1111 : ~(4'b1111 << end_lane);
    assign beat_sel  = (first_q ? head_sel : 4'b1111) & (last_beat ? tail_sel : 4'b1111);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            words_left <= '0;
            beats_left <= '0;
            first_q    <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            if (start) begin
                words_left <= in_words;
                beats_left <= (job.len == '0) ? '0 : out_beats;
                first_q    <= 1'b1;
            end else begin
                if (accept) begin
                    words_left <= words_left - CNT_W'(1);
                end
                if (emit) begin
                    beats_left <= beats_left - CNT_W'(1);
                    first_q    <= 1'b0;
                end
            end
            if (emit) begin
                beat_valid <= 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    // upper three bytes carry into the next beat.
    always_ff @(posedge clk) begin
        if (accept) begin
            stored <= pkt_data[31:8];
        end
        if (emit) begin
            beat.data <= shifted;
            beat.sel  <= beat_sel;
            beat.last <= last_beat;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else $error("beat changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/eth_dma_pkg.sv ====
`default_nettype none

`include "eth_dma_settings.svh"

package eth_dma_pkg;

    // ==========================================================
    // wishbone classic
    // ==========================================================

    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`ETH_DMA_ADDR_W-1:0] adr;
        logic [31:0]                dat;
        logic [3:0]                 sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // ==========================================================
    // datapath
    // ==========================================================

    // one receive job as programmed by the host.
    typedef struct packed {
        logic [`ETH_DMA_ADDR_W-1:0] addr;
        logic [`ETH_DMA_LEN_W-1:0]  len;
    } dma_job_t;

    // realigned beat ready for a memory write.
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  sel;
        logic        last;
    } mem_beat_t;

    typedef enum logic [1:0] {
        idle,
        wait_beat,
        bus_write,
        finish
    } writer_state_t;

    // word index of each register.
    typedef enum logic [1:0] {
        reg_ctrl   = 2'(`ETH_DMA_REG_CTRL >> 2),
        reg_addr   = 2'(`ETH_DMA_REG_ADDR >> 2),
        reg_len    = 2'(`ETH_DMA_REG_LEN >> 2),
        reg_status = 2'(`ETH_DMA_REG_STATUS >> 2)
    } reg_sel_t;

endpackage

`default_nettype wire

// ==== rtl/eth_dma_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_dma_settings.svh"

module eth_dma_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  eth_dma_pkg::wb_req_t  host_req,
    output eth_dma_pkg::wb_rsp_t  host_rsp,
    output eth_dma_pkg::dma_job_t job,
    output logic                  start,
    input  logic                  done
);

    eth_dma_pkg::reg_sel_t      reg_sel;
    logic                       access;
    logic                       wr_en;
    logic                       ack_q;
    logic [31:0]                rd_dat;
    logic                       busy;
    logic                       done_bit;
    logic [`ETH_DMA_ADDR_W-1:0] addr_next;
    logic [31:0]                len_wide;

    // byte-lane merge of a host write.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] wr_val,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = wr_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign reg_sel = eth_dma_pkg::reg_sel_t'(host_req.adr[3:2]);
    assign access  = host_req.cyc & host_req.stb;
    // writes land on the ack cycle.
    assign wr_en   = access & host_req.we & ack_q;

    assign addr_next = merge_bytes(job.addr, host_req.dat, host_req.sel);
    assign len_wide  = merge_bytes(32'(job.len), host_req.dat, host_req.sel);

    assign host_rsp.ack = ack_q;
    assign host_rsp.dat = rd_dat;

    // ack on the second cycle of stb, then low for one.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access & ~ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !ack_q) begin
            case (reg_sel)
                eth_dma_pkg::reg_addr:   rd_dat <= job.addr;
                eth_dma_pkg::reg_len:    rd_dat <= 32'(job.len);
                eth_dma_pkg::reg_status: rd_dat <= {30'd0, done_bit, busy};
                default:                 rd_dat <= 32'd0;
            endcase
        end
    end

    // ==========================================================
    // job registers and status
    // ==========================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start    <= 1'b0;
            busy     <= 1'b0;
            done_bit <= 1'b0;
            job      <= '0;
        end else begin
            start <= 1'b0;
            if (wr_en && !busy) begin
                case (reg_sel)
                    eth_dma_pkg::reg_ctrl: begin
                        if (host_req.sel[0] && host_req.dat[0]) begin
                            start    <= 1'b1;
                            busy     <= 1'b1;
                            done_bit <= 1'b0;
                        end
                    end
                    eth_dma_pkg::reg_addr: job.addr <= addr_next;
                    eth_dma_pkg::reg_len:  job.len  <= len_wide[`ETH_DMA_LEN_W-1:0];
                    default: ;
                endcase
            end
            if (done) begin
                busy     <= 1'b0;
                done_bit <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) host_rsp.ack |=> !host_rsp.ack)
        else $error("host ack held for two cycles");

    // the writer only finishes a job that was started here.
    assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("done pulse with no job running");

endmodule

`default_nettype wire

// ==== rtl/eth_dma_settings.svh ====
`ifndef ETH_DMA_SETTINGS_SVH
`define ETH_DMA_SETTINGS_SVH

// ==========================================================
// widths
// ==========================================================

// memory and register address width.
`define ETH_DMA_ADDR_W 32

// byte length from 0 to 2047.
`define ETH_DMA_LEN_W 11

// ==========================================================
// register byte offsets
// ==========================================================

`define ETH_DMA_REG_CTRL   4'h0
`define ETH_DMA_REG_ADDR   4'h4
`define ETH_DMA_REG_LEN    4'h8
`define ETH_DMA_REG_STATUS 4'hC

`endif

// ==== rtl/eth_dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module eth_dma_top (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_dma_pkg::wb_req_t host_req,
    output eth_dma_pkg::wb_rsp_t host_rsp,
    input  logic [31:0]          pkt_data,
    input  logic                 pkt_valid,
    output logic                 pkt_ready,
    output eth_dma_pkg::wb_req_t mem_req,
    input  eth_dma_pkg::wb_rsp_t mem_rsp
);

    eth_dma_pkg::dma_job_t  job;
    logic                   start;
    logic                   done;
    eth_dma_pkg::mem_beat_t beat;
    logic                   beat_valid;
    logic                   beat_ready;

    // host registers.
    eth_dma_regs eth_dma_regs_i (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .job      (job),
        .start    (start),
        .done     (done)
    );

    // packet words to aligned beats.
    eth_burst_split eth_burst_split_i (
        .clk        (clk),
        .rst        (rst),
        .job        (job),
        .start      (start),
        .pkt_data   (pkt_data),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    eth_dma_writer eth_dma_writer_i (
        .clk        (clk),
        .rst        (rst),
        .job        (job),
        .start      (start),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== rtl/eth_dma_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_dma_settings.svh"

module eth_dma_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_dma_pkg::dma_job_t  job,
    input  logic                   start,
    input  eth_dma_pkg::mem_beat_t beat,
    input  logic                   beat_valid,
    output logic                   beat_ready,
    output eth_dma_pkg::wb_req_t   mem_req,
    input  eth_dma_pkg::wb_rsp_t   mem_rsp,
    output logic                   done
);

    eth_dma_pkg::writer_state_t state;
    eth_dma_pkg::mem_beat_t     beat_q;
    logic [`ETH_DMA_ADDR_W-1:0] word_adr;
    logic                       in_bus;

    assign in_bus     = (state == eth_dma_pkg::bus_write);
    assign beat_ready = (state == eth_dma_pkg::wait_beat);
    assign done       = (state == eth_dma_pkg::finish);

    // ==========================================================
    // wishbone classic write
    // ==========================================================

    assign mem_req.cyc = in_bus;
    assign mem_req.stb = in_bus;
    assign mem_req.we  = in_bus;
    assign mem_req.adr = word_adr;
    assign mem_req.dat = beat_q.data;
    assign mem_req.sel = beat_q.sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= eth_dma_pkg::idle;
            word_adr <= '0;
        end else begin
            case (state)
                eth_dma_pkg::idle: begin
                    if (start) begin
                        // word aligned base with the lanes taken from the selects.
                        word_adr <= {job.addr[`ETH_DMA_ADDR_W-1:2], 2'b00};
                        state    <= (job.len == '0) ? eth_dma_pkg::finish
                                                    : eth_dma_pkg::wait_beat;
                    end
                end
                eth_dma_pkg::wait_beat: begin
                    if (beat_valid) begin
                        state <= eth_dma_pkg::bus_write;
                    end
                end
                eth_dma_pkg::bus_write: begin
                    if (mem_rsp.ack) begin
                        word_adr <= word_adr + `ETH_DMA_ADDR_W'(4);
                        state    <= beat_q.last ? eth_dma_pkg::finish
                                                : eth_dma_pkg::wait_beat;
                    end
                end
                default: begin
                    state <= eth_dma_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ready && beat_valid) begin
            beat_q <= beat;
        end
    end

    // address, data and selects hold until the slave acks.
    assert property (@(posedge clk) disable iff (rst)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req))
        else $error("write dropped or changed before ack");

endmodule

`default_nettype wire

// ==== tb/eth_dma_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "eth_dma_settings.svh"

module eth_dma_tb;

    localparam int          MEM_BYTES  = 512;
    localparam int          MAX_LEN    = 2048;
    localparam int          MAX_CASES  = 24;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] CTRL_ADR   = 32'(`ETH_DMA_REG_CTRL);
    localparam logic [31:0] ADDR_ADR   = 32'(`ETH_DMA_REG_ADDR);
    localparam logic [31:0] LEN_ADR    = 32'(`ETH_DMA_REG_LEN);
    localparam logic [31:0] STATUS_ADR = 32'(`ETH_DMA_REG_STATUS);

    logic                 clk;
    logic                 rst;
    eth_dma_pkg::wb_req_t host_req;
    eth_dma_pkg::wb_rsp_t host_rsp;
    logic [31:0]          pkt_data;
    logic                 pkt_valid;
    logic                 pkt_ready;
    eth_dma_pkg::wb_req_t mem_req;
    eth_dma_pkg::wb_rsp_t mem_rsp = '0;

    logic [7:0] mem [MEM_BYTES];
    logic [7:0] pkt_byte [MAX_LEN + 4];
    int         write_count = 0;
    int         ack_wait = -1;
    bit         slow_mode = 1'b0;

    // case table with name, job and expected write cycles.
    string                 case_name [MAX_CASES];
    eth_dma_pkg::dma_job_t case_job [MAX_CASES];
    int                    case_beats [MAX_CASES];
    int                    num_cases = 0;

    eth_dma_top eth_dma_top_i (
        .clk       (clk),
        .rst       (rst),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .pkt_data  (pkt_data),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    // background mixes 0xA5 with every address bit.
    function automatic logic [7:0] fill_byte(input int a);
        return 8'hA5 ^ a[7:0] ^ {7'd0, a[8]};
    endfunction

    // ==========================================================
    // memory model
    // ==========================================================

    task automatic store_word();
        int base;
        assert (mem_req.we && mem_req.adr[1:0] == 2'b00 && mem_req.adr < 32'(MEM_BYTES))
            else stop_with_error($sformatf("bad memory write cycle at %h", mem_req.adr));
        base = int'(mem_req.adr);
        for (int lane = 0; lane < 4; lane++) begin
            if (mem_req.sel[lane]) begin
                mem[base + lane] = mem_req.dat[8*lane +: 8];
            end
        end
        write_count++;
    endtask

    // ack after 0 to 3 cycles in slow mode.
    always @(negedge clk) begin
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
            ack_wait    = -1;
        end else if (!rst && mem_req.cyc && mem_req.stb) begin
            if (ack_wait < 0) begin
                ack_wait = slow_mode ? int'($urandom_range(3, 0)) : 0;
            end
            if (ack_wait == 0) begin
                store_word();
                mem_rsp.ack = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    // ==========================================================
    // host bus and packet source
    // ==========================================================

    task automatic host_cycle(input logic we, input logic [31:0] reg_adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        host_req     = '0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = reg_adr;
        host_req.dat = wdat;
        host_req.sel = 4'hF;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else stop_with_error("host bus cycle never acked");
        end while (!host_rsp.ack);
        rdat = host_rsp.dat;
        // ack is sampled on the next rising edge.
        @(negedge clk);
        host_req = '0;
    endtask

    task automatic send_packet(input int len);
        int waited;
        int gap;
        for (int w = 0; w < (len + 3) / 4; w++) begin
            gap = slow_mode ? int'($urandom_range(2, 0)) : 0;
            repeat (gap) @(negedge clk);
            pkt_data  = {pkt_byte[4*w+3], pkt_byte[4*w+2], pkt_byte[4*w+1], pkt_byte[4*w]};
            pkt_valid = 1'b1;
            waited = 0;
            while (!pkt_ready) begin
                @(negedge clk);
                waited++;
                assert (waited < WAIT_LIMIT) else stop_with_error("packet word never accepted");
            end
            @(negedge clk);
            pkt_valid = 1'b0;
        end
    endtask

    task automatic wait_done(output logic [31:0] st);
        int polls;
        polls = 0;
        st = '0;
        while (!st[1]) begin
            host_cycle(1'b0, STATUS_ADR, 32'd0, st);
            polls++;
            assert (st[1] || polls < WAIT_LIMIT)
                else stop_with_error("done bit never set in the status register");
        end
    endtask

    // ==========================================================
    // cases
    // ==========================================================

    task automatic add_case(input string name, input logic [31:0] dst,
                            input int nbytes, input int beats);
        case_name[num_cases]     = name;
        case_job[num_cases].addr = dst;
        case_job[num_cases].len  = `ETH_DMA_LEN_W'(nbytes);
        case_beats[num_cases]    = beats;
        num_cases++;
    endtask

    // byte i of the packet lands at addr + i and all else keeps the background.
    task automatic check_image(input string tag, input eth_dma_pkg::dma_job_t job);
        logic [7:0] want;
        int         first;
        first = int'(job.addr);
        for (int a = 0; a < MEM_BYTES; a++) begin
            if (a >= first && a < first + int'(job.len)) begin
                want = pkt_byte[a - first];
            end else begin
                want = fill_byte(a);
            end
            assert (mem[a] === want) else stop_with_error($sformatf(
                "Mismatch %s byte %0h: expected %h, actual %h", tag, a, want, mem[a]));
        end
    endtask

    task automatic run_case(input int idx, input bit slow);
        eth_dma_pkg::dma_job_t job;
        logic [31:0]           st;
        string                 tag;
        job       = case_job[idx];
        tag       = slow ? {case_name[idx], "_slow"} : case_name[idx];
        slow_mode = slow;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = fill_byte(a);
        end
        write_count = 0;
        host_cycle(1'b1, ADDR_ADR, job.addr, st);
        host_cycle(1'b1, LEN_ADR, 32'(job.len), st);
        host_cycle(1'b1, CTRL_ADR, 32'd1, st);
        if (job.len != '0) begin
            host_cycle(1'b0, STATUS_ADR, 32'd0, st);
            assert (st == 32'h1) else stop_with_error($sformatf(
                "Mismatch %s busy status: expected %h, actual %h", tag, 32'h1, st));
        end
        fork
            send_packet(int'(job.len));
            begin
                // a second start while the packet is still moving.
                if (job.len != '0) begin
                    host_cycle(1'b1, CTRL_ADR, 32'd1, st);
                end
                wait_done(st);
            end
        join
        assert (st == 32'h2) else stop_with_error($sformatf(
            "Mismatch %s done status: expected %h, actual %h", tag, 32'h2, st));
        assert (write_count == case_beats[idx]) else stop_with_error($sformatf(
            "Mismatch %s write cycles: expected %0d, actual %0d",
            tag, case_beats[idx], write_count));
        check_image(tag, job);
    endtask

    initial begin
        logic [31:0] st;
        clk       = 1'b0;
        rst       = 1'b1;
        host_req  = '0;
        pkt_data  = '0;
        pkt_valid = 1'b0;
        void'($urandom(52079));

        add_case("aligned_len4",  32'h040, 4, 1);
        add_case("aligned_len5",  32'h080, 5, 2);
        add_case("aligned_len64", 32'h100, 64, 16);
        add_case("aligned_len1",  32'h048, 1, 1);
        add_case("off1_len1",     32'h051, 1, 1);
        add_case("off1_len2",     32'h141, 2, 1);
        add_case("off1_len3",     32'h059, 3, 1);
        add_case("off1_len6",     32'h061, 6, 2);
        add_case("off1_len7",     32'h069, 7, 2);
        add_case("off2_len1",     32'h14A, 1, 1);
        add_case("off2_len2",     32'h072, 2, 1);
        add_case("off2_len3",     32'h07A, 3, 2);
        add_case("off2_len6",     32'h152, 6, 2);
        add_case("off2_len7",     32'h0C2, 7, 3);
        add_case("off3_len1",     32'h0D3, 1, 1);
        add_case("off3_len2",     32'h0DB, 2, 2);
        add_case("off3_len3",     32'h15B, 3, 2);
        add_case("off3_len6",     32'h0E3, 6, 3);
        add_case("off3_len7",     32'h0F3, 7, 3);
        add_case("zero_len",      32'h1C0, 0, 0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!pkt_ready && !mem_req.cyc && !mem_req.stb && !host_rsp.ack)
            else stop_with_error("outputs not low after reset");
        host_cycle(1'b0, STATUS_ADR, 32'd0, st);
        assert (st == 32'h0) else stop_with_error($sformatf(
            "Mismatch reset status: expected %h, actual %h", 32'h0, st));

        for (int idx = 0; idx < num_cases; idx++) begin
            for (int i = 0; i < int'(case_job[idx].len) + 4; i++) begin
                pkt_byte[i] = 8'($urandom);
            end
            run_case(idx, 1'b0);
            run_case(idx, 1'b1);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/eth_dma_pkg.sv
rtl/eth_dma_regs.sv
rtl/eth_burst_split.sv
rtl/eth_dma_writer.sv
rtl/eth_dma_top.sv
tb/eth_dma_tb.sv
